//--- source/imuldiv_pkg.sv
/*
 * shared constants and types for the iterative multiply/divide unit;
 * imported by the RTL and the testbench
 */
package imuldiv_pkg;

  // --------------------------------------------------------------------------
  // function codes carried on the request
  // --------------------------------------------------------------------------

  // signed multiply, signed divide, unsigned divide
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } fn_t;

  // --------------------------------------------------------------------------
  // widths and iteration count
  // --------------------------------------------------------------------------

  // operand width
  localparam int data_width = 32;
  // full product, or remainder in the upper half and quotient in the lower
  localparam int result_width = 64;
  // one calc step per operand bit
  localparam int step_count = 32;
  localparam int step_cnt_width = 5;

  // order queue in the top level, a power of two
  localparam int order_depth = 2;

  // which unit owns a queued response
  typedef enum logic {
    tag_mul = 1'b0,
    tag_div = 1'b1
  } unit_tag_t;

endpackage

//--- source/int_mul_ctrl.sv
/*
 * control FSM of the iterative multiplier; sequences the load, the
 * calc steps and the hold of the result until the response is taken
 */
`timescale 1ns/1ns

module int_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic a_en,
  output logic a_mux_sel,
  output logic b_en,
  output logic b_mux_sel
);
  import imuldiv_pkg::*;

  typedef enum logic [1:0] {st_idle, st_calc, st_done} state_t;

  state_t                    state;
  logic [step_cnt_width-1:0] step_cnt;

  // --------------------------------------------------------------------------
  // state register and step counter
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      step_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          // request taken, operands load on this same edge
          if (req_val) begin
            state    <= st_calc;
            step_cnt <= '0;
          end
        end
        st_calc: begin
          // last of the step_count shift-and-add cycles
          if (step_cnt == step_cnt_width'(step_count - 1)) begin
            state <= st_done;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        st_done: begin
          // hold the product under back-pressure
          if (resp_rdy) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // output decode
  // --------------------------------------------------------------------------

  always_comb begin
    req_rdy   = (state == st_idle);
    resp_val  = (state == st_done);
    // idle: load magnitudes when a request arrives (select 0)
    // calc: shift and accumulate every cycle (select 1)
    a_en      = (state == st_calc) || ((state == st_idle) && req_val);
    b_en      = a_en;
    a_mux_sel = (state == st_calc);
    b_mux_sel = (state == st_calc);
  end

endmodule

//--- source/int_mul_dpath.sv
/*
 * datapath of the iterative multiplier; shift-and-add on operand
 * magnitudes, with the sign of the product applied at the output
 */
`timescale 1ns/1ns

module int_mul_dpath (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [imuldiv_pkg::data_width-1:0]   req_a,
  input  logic [imuldiv_pkg::data_width-1:0]   req_b,
  input  logic                                a_en,
  input  logic                                a_mux_sel,
  input  logic                                b_en,
  input  logic                                b_mux_sel,
  output logic [imuldiv_pkg::result_width-1:0] resp_result
);
  import imuldiv_pkg::*;

  // shifted multiplicand, widened so it can move into the upper half
  logic [result_width-1:0] a_reg;
  // multiplier, consumed one bit per step from the bottom
  logic [data_width-1:0]   b_reg;
  logic [result_width-1:0] prod_reg;
  logic                    sign_a_reg;
  logic                    sign_b_reg;

  logic [data_width-1:0]   a_mag;
  logic [data_width-1:0]   b_mag;
  logic [result_width-1:0] a_mux_out;
  logic [data_width-1:0]   b_mux_out;

  // magnitudes of the incoming operands
  assign a_mag = req_a[data_width-1] ? -req_a : req_a;
  assign b_mag = req_b[data_width-1] ? -req_b : req_b;

  assign a_mux_out = a_mux_sel ? (a_reg << 1) : {{data_width{1'b0}}, a_mag};
  assign b_mux_out = b_mux_sel ? (b_reg >> 1) : b_mag;

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    if (b_en) begin
      b_reg <= b_mux_out;
    end
  end

  // --------------------------------------------------------------------------
  // partial product and saved signs
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_reg   <= '0;
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
    end else if (a_en && !a_mux_sel) begin
      // load: start a fresh product
      prod_reg   <= '0;
      sign_a_reg <= req_a[data_width-1];
      sign_b_reg <= req_b[data_width-1];
    end else if (a_en && b_reg[0]) begin
      // add the shifted multiplicand where the multiplier bit is set
      prod_reg <= prod_reg + a_reg;
    end
  end

  // negative product when exactly one operand was negative
  assign resp_result = (sign_a_reg ^ sign_b_reg) ? -prod_reg : prod_reg;

endmodule

//--- source/int_mul_iterative.sv
/*
 * iterative signed multiplier; control FSM plus shift-and-add datapath
 * behind a valid/ready request and response
 */
`timescale 1ns/1ns

module int_mul_iterative (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [imuldiv_pkg::data_width-1:0]   req_a,
  input  logic [imuldiv_pkg::data_width-1:0]   req_b,
  input  logic                                req_val,
  output logic                                req_rdy,
  output logic [imuldiv_pkg::result_width-1:0] resp_result,
  output logic                                resp_val,
  input  logic                                resp_rdy
);

  // register enables and load/shift selects from control to datapath
  logic a_en;
  logic a_mux_sel;
  logic b_en;
  logic b_mux_sel;

  int_mul_ctrl i_ctrl (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .a_en      (a_en),
    .a_mux_sel (a_mux_sel),
    .b_en      (b_en),
    .b_mux_sel (b_mux_sel)
  );

  int_mul_dpath i_dpath (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .a_en        (a_en),
    .a_mux_sel   (a_mux_sel),
    .b_en        (b_en),
    .b_mux_sel   (b_mux_sel),
    .resp_result (resp_result)
  );

endmodule

//--- source/int_div_iterative.sv
/*
 * iterative restoring divider for signed and unsigned divide; result is
 * the remainder in the upper half and the quotient in the lower half
 */
`timescale 1ns/1ns

module int_div_iterative (
  input  logic                                clk,
  input  logic                                reset,
  input  imuldiv_pkg::fn_t                    req_fn,
  input  logic [imuldiv_pkg::data_width-1:0]   req_a,
  input  logic [imuldiv_pkg::data_width-1:0]   req_b,
  input  logic                                req_val,
  output logic                                req_rdy,
  output logic [imuldiv_pkg::result_width-1:0] resp_result,
  output logic                                resp_val,
  input  logic                                resp_rdy
);
  import imuldiv_pkg::*;

  typedef enum logic [1:0] {st_idle, st_calc, st_done} state_t;

  state_t                    state;
  logic [step_cnt_width-1:0] step_cnt;

  // remainder high, quotient low; the dividend starts in the low half
  logic [result_width-1:0]   rq_reg;
  logic [data_width-1:0]     divisor_reg;
  logic                      neg_quot;
  logic                      neg_rem;
  logic                      div_zero;

  logic                      is_signed;
  logic [data_width-1:0]     a_in;
  logic [data_width-1:0]     b_in;
  logic [data_width:0]       rem_shift;
  logic [data_width+1:0]     diff;
  logic [data_width-1:0]     rem_next;
  logic [data_width-1:0]     quot_raw;
  logic [data_width-1:0]     rem_raw;
  logic [data_width-1:0]     quot_out;
  logic [data_width-1:0]     rem_out;

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);

  // --------------------------------------------------------------------------
  // control
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      step_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_val) begin
            state    <= st_calc;
            step_cnt <= '0;
          end
        end
        st_calc: begin
          if (step_cnt == step_cnt_width'(step_count - 1)) begin
            state <= st_done;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        st_done: begin
          if (resp_rdy) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // datapath
  // --------------------------------------------------------------------------

  // signed divide works on magnitudes, unsigned takes the raw bits
  assign is_signed = (req_fn == fn_div);
  assign a_in = (is_signed && req_a[data_width-1]) ? -req_a : req_a;
  assign b_in = (is_signed && req_b[data_width-1]) ? -req_b : req_b;

  // remainder shifted left with the next dividend bit, one bit wider
  assign rem_shift = rq_reg[result_width-1:data_width-1];
  // trial subtract; top bit set means the divisor did not fit
  assign diff      = {1'b0, rem_shift} - {2'b00, divisor_reg};
  assign rem_next  = diff[data_width+1] ? rem_shift[data_width-1:0]
                                        : diff[data_width-1:0];

  always_ff @(posedge clk) begin
    if (req_val && req_rdy) begin
      rq_reg      <= {{data_width{1'b0}}, a_in};
      divisor_reg <= b_in;
      neg_quot    <= is_signed && (req_a[data_width-1] ^ req_b[data_width-1]);
      // remainder follows the dividend
      neg_rem     <= is_signed && req_a[data_width-1];
      div_zero    <= (req_b == '0);
    end else if (state == st_calc) begin
      rq_reg <= {rem_next, rq_reg[data_width-2:0], ~diff[data_width+1]};
    end
  end

  // sign fix-up in done
  // min / -1 gives magnitude 2^31, whose negation is min again
  // divide by zero leaves the dividend in the remainder on its own
  assign quot_raw = rq_reg[data_width-1:0];
  assign rem_raw  = rq_reg[result_width-1:data_width];
  assign quot_out = div_zero ? '1 : (neg_quot ? -quot_raw : quot_raw);
  assign rem_out  = neg_rem ? -rem_raw : rem_raw;

  assign resp_result = {rem_out, quot_out};

endmodule

//--- source/int_muldiv_iterative.sv
/*
 * multiply/divide top level; sends each request to its unit and returns
 * responses in request order through a small tag queue
 */
`timescale 1ns/1ns

module int_muldiv_iterative (
  input  logic                                clk,
  input  logic                                reset,
  input  imuldiv_pkg::fn_t                    req_fn,
  input  logic [imuldiv_pkg::data_width-1:0]   req_a,
  input  logic [imuldiv_pkg::data_width-1:0]   req_b,
  input  logic                                req_val,
  output logic                                req_rdy,
  output logic [imuldiv_pkg::result_width-1:0] resp_result,
  output logic                                resp_val,
  input  logic                                resp_rdy
);
  import imuldiv_pkg::*;

  logic                          mul_req_val;
  logic                          mul_req_rdy;
  logic [result_width-1:0]       mul_resp_result;
  logic                          mul_resp_val;
  logic                          mul_resp_rdy;
  logic                          div_req_val;
  logic                          div_req_rdy;
  logic [result_width-1:0]       div_resp_result;
  logic                          div_resp_val;
  logic                          div_resp_rdy;

  // order queue, pointers wrap because the depth is a power of two
  unit_tag_t                     tag_q [order_depth];
  logic [$clog2(order_depth)-1:0]   wr_ptr;
  logic [$clog2(order_depth)-1:0]   rd_ptr;
  logic [$clog2(order_depth+1)-1:0] count;

  logic      is_mul;
  logic      q_full;
  logic      q_empty;
  logic      push;
  logic      pop;
  unit_tag_t head_tag;

  // --------------------------------------------------------------------------
  // dispatch
  // --------------------------------------------------------------------------

  assign is_mul  = (req_fn == fn_mul);
  assign q_full  = (count == order_depth);
  assign q_empty = (count == '0);

  // units only see valid when the queue can take their tag
  assign mul_req_val = req_val && is_mul && !q_full;
  assign div_req_val = req_val && !is_mul && !q_full;
  assign req_rdy     = (is_mul ? mul_req_rdy : div_req_rdy) && !q_full;

  // --------------------------------------------------------------------------
  // response steering, head of the queue owns the response port
  // --------------------------------------------------------------------------

  assign head_tag     = tag_q[rd_ptr];
  assign resp_val     = !q_empty && ((head_tag == tag_mul) ? mul_resp_val : div_resp_val);
  assign resp_result  = (head_tag == tag_mul) ? mul_resp_result : div_resp_result;
  assign mul_resp_rdy = resp_rdy && !q_empty && (head_tag == tag_mul);
  assign div_resp_rdy = resp_rdy && !q_empty && (head_tag == tag_div);

  assign push = req_val && req_rdy;
  assign pop  = resp_val && resp_rdy;

  always_ff @(posedge clk) begin
    if (push) begin
      tag_q[wr_ptr] <= is_mul ? tag_mul : tag_div;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the count unchanged
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  int_mul_iterative i_mul (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .resp_result (mul_resp_result),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy)
  );

  int_div_iterative i_div (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .resp_result (div_resp_result),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy)
  );

endmodule

//--- sim/imuldiv_checker.sv
/*
 * response checker for the multiply/divide testbench; reads the expected
 * results from the test file and compares every response transfer in order
 */
`timescale 1ns/1ns

module imuldiv_checker (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                req_val,
  input  logic                                req_rdy,
  input  logic [imuldiv_pkg::result_width-1:0] resp_result,
  input  logic                                resp_val,
  input  logic                                resp_rdy,
  input  logic                                report,
  output int                                  resp_count,
  output int                                  error_count
);
  import imuldiv_pkg::*;

  // tests in file order, popped one per response
  fn_t                     fn_q [$];
  logic [data_width-1:0]   a_q [$];
  logic [data_width-1:0]   b_q [$];
  logic [result_width-1:0] exp_q [$];

  fn_t                     cur_fn;
  logic [data_width-1:0]   cur_a;
  logic [data_width-1:0]   cur_b;
  logic [result_width-1:0] cur_exp;

  int                      test_count;
  int                      req_count;

  initial begin
    int                      fd;
    int                      code;
    string                   line;
    logic [1:0]              fn_raw;
    logic [data_width-1:0]   a;
    logic [data_width-1:0]   b;
    logic [result_width-1:0] expected;
    test_count  = 0;
    req_count   = 0;
    resp_count  = 0;
    error_count = 0;
    fd = $fopen("sim/imuldiv_tests.txt", "r");
    if (fd == 0) begin
      $display("checker could not open the test file");
      error_count++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        // comment and blank lines carry no test
        if (code > 0 && line.len() > 0 && line[0] != "#") begin
          if ($sscanf(line, "%h %h %h %h", fn_raw, a, b, expected) == 4) begin
            fn_q.push_back(fn_t'(fn_raw));
            a_q.push_back(a);
            b_q.push_back(b);
            exp_q.push_back(expected);
          end
        end
      end
      $fclose(fd);
      test_count = exp_q.size();
    end
  end

  // ------------------------------------------------------------------------
  // handshake monitor, sampled mid-cycle where inputs and outputs are settled
  // ------------------------------------------------------------------------

  always @(negedge clk) begin
    if (!reset) begin
      if (resp_val && resp_rdy) begin
        // a response needs a request accepted on an earlier edge
        if (resp_count >= req_count) begin
          error_count++;
          $display("response at %0t ns came with no request outstanding", $time);
        end
        if (exp_q.size() == 0) begin
          error_count++;
          $display("extra response at %0t ns after all tests were answered", $time);
        end else begin
          cur_fn  = fn_q.pop_front();
          cur_a   = a_q.pop_front();
          cur_b   = b_q.pop_front();
          cur_exp = exp_q.pop_front();
          if (resp_result !== cur_exp) begin
            error_count++;
            $display("Fail at %0t ns: test %0d %s a=%h b=%h got %h expected %h",
                     $time, resp_count, cur_fn.name(), cur_a, cur_b, resp_result, cur_exp);
          end else begin
            $display("test %0d %s a=%h b=%h result %h ok",
                     resp_count, cur_fn.name(), cur_a, cur_b, resp_result);
          end
        end
        resp_count++;
      end
      if (req_val && req_rdy) begin
        req_count++;
      end
    end
  end

  // closing counts; lost or duplicated responses count as errors
  always @(posedge report) begin
    if (resp_count != test_count) begin
      error_count++;
      $display("count mismatch: %0d tests in the file but %0d responses",
               test_count, resp_count);
    end
    $display("summary: %0d tests, %0d requests, %0d responses, %0d errors",
             test_count, req_count, resp_count, error_count);
  end

endmodule

//--- sim/tb_imuldiv.sv
/*
 * testbench for the multiply/divide top level; drives the requests of the
 * test file with random gaps and random response back-pressure
 */
`timescale 1ns/1ns

module tb_imuldiv;
  import imuldiv_pkg::*;

  localparam int clk_half        = 20;
  localparam int drive_delay     = 2;
  localparam int reset_cycles    = 5;
  localparam int cycles_per_test = 200;
  // chance in percent that resp_rdy is low in a cycle
  localparam int stall_pct       = 30;
  // idle cycles after the last response to catch a duplicate
  localparam int drain_cycles    = 8;

  logic                    clk = 1'b0;
  logic                    reset;
  fn_t                     req_fn;
  logic [data_width-1:0]   req_a;
  logic [data_width-1:0]   req_b;
  logic                    req_val;
  logic                    req_rdy;
  logic [result_width-1:0] resp_result;
  logic                    resp_val;
  logic                    resp_rdy;
  logic                    report;

  int resp_count;
  int error_count;

  // requests in file order
  fn_t                     fn_list [$];
  logic [data_width-1:0]   a_list [$];
  logic [data_width-1:0]   b_list [$];
  int                      num_tests = 0;
  logic                    load_ok = 1'b0;

  always #clk_half clk = ~clk;

  int_muldiv_iterative i_int_muldiv_iterative (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  imuldiv_checker i_checker (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .report      (report),
    .resp_count  (resp_count),
    .error_count (error_count)
  );

  // ------------------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------------------

  task automatic load_tests();
    int                      fd;
    int                      code;
    string                   line;
    logic [1:0]              fn_raw;
    logic [data_width-1:0]   a;
    logic [data_width-1:0]   b;
    logic [result_width-1:0] expected;
    fd = $fopen("sim/imuldiv_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/imuldiv_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 0 && line[0] != "#") begin
          if ($sscanf(line, "%h %h %h %h", fn_raw, a, b, expected) == 4) begin
            fn_list.push_back(fn_t'(fn_raw));
            a_list.push_back(a);
            b_list.push_back(b);
          end
        end
      end
      $fclose(fd);
      num_tests = fn_list.size();
      load_ok   = (num_tests > 0);
    end
  endtask

  // idle cycles between requests, each ending just after an edge
  task automatic idle_gap(input int unsigned cycles);
    repeat (cycles) begin
      @(posedge clk);
      #drive_delay;
    end
  endtask

  // hold the request until a rising edge sees valid and ready together
  task automatic send_request(input fn_t fn, input logic [data_width-1:0] a,
                              input logic [data_width-1:0] b);
    logic taken;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
    taken   = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = req_rdy;
      @(posedge clk);
      #drive_delay;
    end
    req_val = 1'b0;
  endtask

  // random back-pressure on the response side
  always begin
    @(posedge clk);
    #drive_delay;
    resp_rdy = (($urandom % 100) >= stall_pct);
  end

  initial begin
    void'($urandom(32'h076a855a));
    reset    = 1'b1;
    req_fn   = fn_mul;
    req_a    = '0;
    req_b    = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    report   = 1'b0;
    load_tests();
    if (load_ok) begin
      repeat (reset_cycles) @(posedge clk);
      #drive_delay;
      reset = 1'b0;
      for (int i = 0; i < num_tests; i++) begin
        idle_gap($urandom % 4);
        send_request(fn_list[i], a_list[i], b_list[i]);
      end
      wait (resp_count == num_tests);
      repeat (drain_cycles) @(posedge clk);
    end else begin
      $display("no tests could be read from the test file");
    end
    report = 1'b1;
    #1;
    if (load_ok && error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog, scaled by the number of tests
  initial begin
    wait (load_ok);
    repeat (num_tests * cycles_per_test) @(posedge clk);
    $display("run timed out after %0d cycles with %0d of %0d responses",
             num_tests * cycles_per_test, resp_count, num_tests);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- sim/imuldiv_tests.txt
# columns: fn (0 mul, 1 div, 2 divu), operand a, operand b, expected result, all hex
# expected is the full product, or remainder in the high word and quotient in the low word
0 00000007 00000006 000000000000002a
1 00000007 00000002 0000000100000003
0 fffffffd 00000005 fffffffffffffff1
1 fffffff9 00000002 fffffffffffffffd
0 fffffff9 fffffffa 000000000000002a
1 00000007 fffffffe 00000001fffffffd
0 00000000 12345678 0000000000000000
1 fffffff9 fffffffe ffffffff00000003
0 80000000 80000000 4000000000000000
2 fffffffe 00000003 0000000255555554
0 80000000 00000001 ffffffff80000000
2 80000000 80000001 8000000000000000
0 7fffffff 7fffffff 3fffffff00000001
1 00000005 00000000 00000005ffffffff
0 80000000 ffffffff 0000000080000000
1 fffffffb 00000000 fffffffbffffffff
0 0000ffff 0000ffff 00000000fffe0001
1 80000000 ffffffff 0000000080000000
2 ffffffff 00000000 ffffffffffffffff
2 ffffffff 0000000f 0000000011111111
1 80000000 00000002 00000000c0000000

//--- filelist.f
source/imuldiv_pkg.sv
source/int_mul_ctrl.sv
source/int_mul_dpath.sv
source/int_mul_iterative.sv
source/int_div_iterative.sv
source/int_muldiv_iterative.sv
sim/imuldiv_checker.sv
sim/tb_imuldiv.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the multiply/divide testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_imuldiv -Mdir obj_dir -f filelist.f \
  && ./obj_dir/Vtb_imuldiv > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "PASS: all tests" sim.log && exit 0 || exit 1
